//--- src/axi_mmio_pkg.sv
// Fixed AXI field widths and beat types; QoS, region, lock and user sideband fields are not carried
`default_nettype none

package axi_mmio_pkg;

    // --------------------------------------------------
    // Field widths
    // --------------------------------------------------
    localparam int ID_W    = 9;
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 64;
    localparam int STRB_W  = 8;
    localparam int LEN_W   = 8;
    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;
    localparam int CACHE_W = 4;
    localparam int PROT_W  = 3;
    localparam int RESP_W  = 2;

    // Stage kind per channel
    typedef enum logic [1:0] {
        REG_SKID   = 2'd0,
        REG_SIMPLE = 2'd1,
        REG_BYPASS = 2'd2
    } reg_mode_e;

    // --------------------------------------------------
    // Channel beats
    // --------------------------------------------------
    // Address request, shared by AW and AR (61 bits)
    typedef struct packed {
        logic [ID_W-1:0]    id;
        logic [ADDR_W-1:0]  addr;
        logic [LEN_W-1:0]   len;
        logic [SIZE_W-1:0]  size;
        logic [BURST_W-1:0] burst;
        logic [CACHE_W-1:0] cache;
        logic [PROT_W-1:0]  prot;
    } aw_beat_t;

    typedef aw_beat_t ar_beat_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_beat_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [RESP_W-1:0] resp;
    } b_beat_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [RESP_W-1:0] resp;
        logic              last;
    } r_beat_t;

endpackage

`default_nettype wire

//--- src/axi_pipe_stage.sv
// Single valid/ready stage; skid and simple forms add one cycle of latency, bypass adds none
`default_nettype none
`timescale 1ns/10ps

module axi_pipe_stage
    import axi_mmio_pkg::*;
#(
    parameter reg_mode_e MODE      = REG_SKID,
    parameter type       payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_n,

    // Upstream side
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    // Downstream side
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    generate
        if (MODE == REG_SKID) begin : g_skid
            // --------------------------------------------------
            // Skid buffer, ready path fully registered
            // --------------------------------------------------
            logic     main_valid_q;
            logic     skid_valid_q;
            logic     ready_q;
            payload_t main_q;
            payload_t skid_q;

            logic     in_fire;
            logic     main_free;
            logic     main_valid_d;
            logic     skid_valid_d;

            assign in_fire   = in_valid & ready_q;
            // Main register drains or is empty this cycle
            assign main_free = ~main_valid_q | out_ready;

            // Skid entry only fills while main is stalled
            always_comb begin
                if (main_free) begin
                    main_valid_d = skid_valid_q | in_fire;
                    skid_valid_d = 1'b0;
                end else begin
                    main_valid_d = 1'b1;
                    skid_valid_d = skid_valid_q | in_fire;
                end
            end

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    main_valid_q <= 1'b0;
                    skid_valid_q <= 1'b0;
                    ready_q      <= 1'b1;
                end else begin
                    main_valid_q <= main_valid_d;
                    skid_valid_q <= skid_valid_d;
                    ready_q      <= ~skid_valid_d;
                end
            end

            always_ff @(posedge clk) begin
                if (main_free) begin
                    main_q <= skid_valid_q ? skid_q : in_data;
                end
                if (!main_free && in_fire) begin
                    skid_q <= in_data;
                end
            end

            assign in_ready  = ready_q;
            assign out_valid = main_valid_q;
            assign out_data  = main_q;

        end else if (MODE == REG_SIMPLE) begin : g_simple
            // --------------------------------------------------
            // Single entry, ready follows downstream
            // --------------------------------------------------
            logic     valid_q;
            payload_t data_q;

            assign in_ready = ~valid_q | out_ready;

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    valid_q <= 1'b0;
                end else if (in_ready) begin
                    valid_q <= in_valid;
                end
            end

            always_ff @(posedge clk) begin
                if (in_valid && in_ready) begin
                    data_q <= in_data;
                end
            end

            assign out_valid = valid_q;
            assign out_data  = data_q;

        end else begin : g_bypass
            // Straight wires, zero latency
            assign out_valid = in_valid;
            assign out_data  = in_data;
            assign in_ready  = out_ready;
        end
    endgenerate

endmodule

`default_nettype wire

//--- src/axi_register.sv
// One register slice on all five AXI channels; channels are independent, no cross-channel ordering
`default_nettype none
`timescale 1ns/10ps

module axi_register
    import axi_mmio_pkg::*;
#(
    parameter reg_mode_e AW_MODE = REG_SKID,
    parameter reg_mode_e W_MODE  = REG_SKID,
    parameter reg_mode_e B_MODE  = REG_SKID,
    parameter reg_mode_e AR_MODE = REG_SKID,
    parameter reg_mode_e R_MODE  = REG_SKID
) (
    input  logic     clk,
    input  logic     rst_n,

    // --------------------------------------------------
    // User side
    // --------------------------------------------------
    input  logic     s_awvalid,
    output logic     s_awready,
    input  aw_beat_t s_aw,

    input  logic     s_wvalid,
    output logic     s_wready,
    input  w_beat_t  s_w,

    output logic     s_bvalid,
    input  logic     s_bready,
    output b_beat_t  s_b,

    input  logic     s_arvalid,
    output logic     s_arready,
    input  ar_beat_t s_ar,

    output logic     s_rvalid,
    input  logic     s_rready,
    output r_beat_t  s_r,

    // --------------------------------------------------
    // Memory side
    // --------------------------------------------------
    output logic     m_awvalid,
    input  logic     m_awready,
    output aw_beat_t m_aw,

    output logic     m_wvalid,
    input  logic     m_wready,
    output w_beat_t  m_w,

    input  logic     m_bvalid,
    output logic     m_bready,
    input  b_beat_t  m_b,

    output logic     m_arvalid,
    input  logic     m_arready,
    output ar_beat_t m_ar,

    input  logic     m_rvalid,
    output logic     m_rready,
    input  r_beat_t  m_r
);

    // Write address, user to memory
    axi_pipe_stage #(
        .MODE      (AW_MODE),
        .payload_t (aw_beat_t)
    ) i_aw_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (s_awvalid),
        .in_ready  (s_awready),
        .in_data   (s_aw),
        .out_valid (m_awvalid),
        .out_ready (m_awready),
        .out_data  (m_aw)
    );

    // Write data, user to memory
    axi_pipe_stage #(
        .MODE      (W_MODE),
        .payload_t (w_beat_t)
    ) i_w_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (s_wvalid),
        .in_ready  (s_wready),
        .in_data   (s_w),
        .out_valid (m_wvalid),
        .out_ready (m_wready),
        .out_data  (m_w)
    );

    // Write response runs the other way, memory to user
    axi_pipe_stage #(
        .MODE      (B_MODE),
        .payload_t (b_beat_t)
    ) i_b_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (m_bvalid),
        .in_ready  (m_bready),
        .in_data   (m_b),
        .out_valid (s_bvalid),
        .out_ready (s_bready),
        .out_data  (s_b)
    );

    // Read address, user to memory
    axi_pipe_stage #(
        .MODE      (AR_MODE),
        .payload_t (ar_beat_t)
    ) i_ar_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (s_arvalid),
        .in_ready  (s_arready),
        .in_data   (s_ar),
        .out_valid (m_arvalid),
        .out_ready (m_arready),
        .out_data  (m_ar)
    );

    // Read data, memory to user
    axi_pipe_stage #(
        .MODE      (R_MODE),
        .payload_t (r_beat_t)
    ) i_r_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (m_rvalid),
        .in_ready  (m_rready),
        .in_data   (m_r),
        .out_valid (s_rvalid),
        .out_ready (s_rready),
        .out_data  (s_r)
    );

endmodule

`default_nettype wire

//--- src/axi_mmio_register.sv
// AXI pipeline of NUM_PIPELINES slices (0 gives wires); freeze holds AW/W/AR beats, B and R never frozen
`default_nettype none
`timescale 1ns/10ps

module axi_mmio_register
    import axi_mmio_pkg::*;
#(
    parameter int unsigned NUM_PIPELINES = 1,
    parameter reg_mode_e   AW_MODE       = REG_SKID,
    parameter reg_mode_e   W_MODE        = REG_SKID,
    parameter reg_mode_e   B_MODE        = REG_SKID,
    parameter reg_mode_e   AR_MODE       = REG_SKID,
    parameter reg_mode_e   R_MODE        = REG_SKID
) (
    input  logic     clk,
    input  logic     rst_n,
    // High during partial reconfiguration of the user region
    input  logic     freeze,

    // User side
    input  logic     s_awvalid,
    output logic     s_awready,
    input  aw_beat_t s_aw,
    input  logic     s_wvalid,
    output logic     s_wready,
    input  w_beat_t  s_w,
    output logic     s_bvalid,
    input  logic     s_bready,
    output b_beat_t  s_b,
    input  logic     s_arvalid,
    output logic     s_arready,
    input  ar_beat_t s_ar,
    output logic     s_rvalid,
    input  logic     s_rready,
    output r_beat_t  s_r,

    // Memory side
    output logic     m_awvalid,
    input  logic     m_awready,
    output aw_beat_t m_aw,
    output logic     m_wvalid,
    input  logic     m_wready,
    output w_beat_t  m_w,
    input  logic     m_bvalid,
    output logic     m_bready,
    input  b_beat_t  m_b,
    output logic     m_arvalid,
    input  logic     m_arready,
    output ar_beat_t m_ar,
    input  logic     m_rvalid,
    output logic     m_rready,
    input  r_beat_t  m_r
);

    // --------------------------------------------------
    // Chain links, index 0 is the user side
    // --------------------------------------------------
    logic     aw_valid [0:NUM_PIPELINES];
    logic     aw_ready [0:NUM_PIPELINES];
    aw_beat_t aw_data  [0:NUM_PIPELINES];
    logic     w_valid  [0:NUM_PIPELINES];
    logic     w_ready  [0:NUM_PIPELINES];
    w_beat_t  w_data   [0:NUM_PIPELINES];
    logic     b_valid  [0:NUM_PIPELINES];
    logic     b_ready  [0:NUM_PIPELINES];
    b_beat_t  b_data   [0:NUM_PIPELINES];
    logic     ar_valid [0:NUM_PIPELINES];
    logic     ar_ready [0:NUM_PIPELINES];
    ar_beat_t ar_data  [0:NUM_PIPELINES];
    logic     r_valid  [0:NUM_PIPELINES];
    logic     r_ready  [0:NUM_PIPELINES];
    r_beat_t  r_data   [0:NUM_PIPELINES];

    genvar i;
    generate
        for (i = 0; i < NUM_PIPELINES; i++) begin : g_slice
            axi_register #(
                .AW_MODE (AW_MODE),
                .W_MODE  (W_MODE),
                .B_MODE  (B_MODE),
                .AR_MODE (AR_MODE),
                .R_MODE  (R_MODE)
            ) i_slice (
                .clk       (clk),
                .rst_n     (rst_n),
                .s_awvalid (aw_valid[i]),   .s_awready (aw_ready[i]),   .s_aw (aw_data[i]),
                .s_wvalid  (w_valid[i]),    .s_wready  (w_ready[i]),    .s_w  (w_data[i]),
                .s_bvalid  (b_valid[i]),    .s_bready  (b_ready[i]),    .s_b  (b_data[i]),
                .s_arvalid (ar_valid[i]),   .s_arready (ar_ready[i]),   .s_ar (ar_data[i]),
                .s_rvalid  (r_valid[i]),    .s_rready  (r_ready[i]),    .s_r  (r_data[i]),
                .m_awvalid (aw_valid[i+1]), .m_awready (aw_ready[i+1]), .m_aw (aw_data[i+1]),
                .m_wvalid  (w_valid[i+1]),  .m_wready  (w_ready[i+1]),  .m_w  (w_data[i+1]),
                .m_bvalid  (b_valid[i+1]),  .m_bready  (b_ready[i+1]),  .m_b  (b_data[i+1]),
                .m_arvalid (ar_valid[i+1]), .m_arready (ar_ready[i+1]), .m_ar (ar_data[i+1]),
                .m_rvalid  (r_valid[i+1]),  .m_rready  (r_ready[i+1]),  .m_r  (r_data[i+1])
            );
        end
    endgenerate

    // User side chain ends
    assign aw_valid[0] = s_awvalid;
    assign aw_data[0]  = s_aw;
    assign s_awready   = aw_ready[0];
    assign w_valid[0]  = s_wvalid;
    assign w_data[0]   = s_w;
    assign s_wready    = w_ready[0];
    assign ar_valid[0] = s_arvalid;
    assign ar_data[0]  = s_ar;
    assign s_arready   = ar_ready[0];
    assign s_bvalid    = b_valid[0];
    assign s_b         = b_data[0];
    assign b_ready[0]  = s_bready;
    assign s_rvalid    = r_valid[0];
    assign s_r         = r_data[0];
    assign r_ready[0]  = s_rready;

    // --------------------------------------------------
    // Memory side, requests held back while frozen
    // --------------------------------------------------
    // Ready gated too, so the last slice never sees a transfer during freeze
    assign m_awvalid = aw_valid[NUM_PIPELINES] & ~freeze;
    assign aw_ready[NUM_PIPELINES] = m_awready & ~freeze;
    assign m_aw      = aw_data[NUM_PIPELINES];
    assign m_wvalid  = w_valid[NUM_PIPELINES] & ~freeze;
    assign w_ready[NUM_PIPELINES]  = m_wready & ~freeze;
    assign m_w       = w_data[NUM_PIPELINES];
    assign m_arvalid = ar_valid[NUM_PIPELINES] & ~freeze;
    assign ar_ready[NUM_PIPELINES] = m_arready & ~freeze;
    assign m_ar      = ar_data[NUM_PIPELINES];

    // Responses pass untouched
    assign b_valid[NUM_PIPELINES] = m_bvalid;
    assign b_data[NUM_PIPELINES]  = m_b;
    assign m_bready               = b_ready[NUM_PIPELINES];
    assign r_valid[NUM_PIPELINES] = m_rvalid;
    assign r_data[NUM_PIPELINES]  = m_r;
    assign m_rready               = r_ready[NUM_PIPELINES];

endmodule

`default_nettype wire

//--- test/tb_channel_checker.sv
// Scoreboard for one valid/ready channel; samples on the falling edge and expects in-order delivery
`default_nettype none
`timescale 1ns/10ps

module tb_channel_checker #(
    parameter type   beat_t   = logic,
    parameter string SIG      = "beat",
    // Most beats the path may hold at once
    parameter int    CAPACITY = 0
) (
    input  logic  clk,

    // Entry side of the channel
    input  logic  in_valid,
    input  logic  in_ready,
    input  beat_t in_data,

    // Exit side of the channel
    input  logic  out_valid,
    input  logic  out_ready,
    input  beat_t out_data,

    output int    pending,
    output logic  error
);

    beat_t expected_q[$];
    bit    failed;

    assign error = failed;

    task automatic compare_beat(input beat_t expected, input beat_t actual);
        if (actual !== expected) begin
            $display("ERROR: %s expected %h, actual %h", SIG, expected, actual);
            failed = 1'b1;
        end
    endtask

    // --------------------------------------------------
    // Queue on entry, pop and compare on exit
    // --------------------------------------------------
    always @(negedge clk) begin : sample
        beat_t expected;
        if (in_valid && in_ready) begin
            expected_q.push_back(in_data);
        end
        if (out_valid && out_ready) begin
            if (expected_q.size() == 0) begin
                $display("A beat left on %s while none was outstanding", SIG);
                failed = 1'b1;
            end else begin
                expected = expected_q.pop_front();
                compare_beat(expected, out_data);
            end
        end
        // Beats held anywhere along the chain
        if (expected_q.size() > CAPACITY) begin
            $display("ERROR: %s in flight expected at most %h, actual %h",
                     SIG, CAPACITY, expected_q.size());
            failed = 1'b1;
        end
        pending = expected_q.size();
    end

endmodule

`default_nettype wire

//--- test/tb_axi_mmio_register.sv
// Fixed-seed random test of a two-slice chain; R must be built from bypass stages, AW and B must not
`default_nettype none
`timescale 1ns/10ps

module tb_axi_mmio_register
    import axi_mmio_pkg::*;
();

    localparam int NUM_PIPES  = 2;
    localparam int WAIT_LIMIT = 2000;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     freeze;
    logic     s_awvalid, s_awready, m_awvalid, m_awready;
    aw_beat_t s_aw, m_aw;
    logic     s_wvalid, s_wready, m_wvalid, m_wready;
    w_beat_t  s_w, m_w;
    logic     s_bvalid, s_bready, m_bvalid, m_bready;
    b_beat_t  s_b, m_b;
    logic     s_arvalid, s_arready, m_arvalid, m_arready;
    ar_beat_t s_ar, m_ar;
    logic     s_rvalid, s_rready, m_rvalid, m_rready;
    r_beat_t  s_r, m_r;

    // Stimulus controls, only changed on the falling edge
    bit          stim_on;
    int unsigned req_rate;
    int unsigned rdy_rate;
    int          pending [5];
    logic [4:0]  chk_err;
    int          frozen_b;
    int          frozen_r;

    always #5 clk = ~clk;

    axi_mmio_register #(
        .NUM_PIPELINES (NUM_PIPES),
        .AW_MODE       (REG_SKID),
        .W_MODE        (REG_SIMPLE),
        .B_MODE        (REG_SKID),
        .AR_MODE       (REG_SIMPLE),
        .R_MODE        (REG_BYPASS)
    ) i_dut (.*);

    // --------------------------------------------------
    // Scoreboards, capacity 2 per skid and 1 per simple stage
    // --------------------------------------------------
    tb_channel_checker #(.beat_t(aw_beat_t), .SIG("m_aw"), .CAPACITY(2 * NUM_PIPES)) i_aw_check (
        .clk(clk), .in_valid(s_awvalid), .in_ready(s_awready), .in_data(s_aw),
        .out_valid(m_awvalid), .out_ready(m_awready), .out_data(m_aw),
        .pending(pending[0]), .error(chk_err[0]));
    tb_channel_checker #(.beat_t(w_beat_t), .SIG("m_w"), .CAPACITY(NUM_PIPES)) i_w_check (
        .clk(clk), .in_valid(s_wvalid), .in_ready(s_wready), .in_data(s_w),
        .out_valid(m_wvalid), .out_ready(m_wready), .out_data(m_w),
        .pending(pending[1]), .error(chk_err[1]));
    tb_channel_checker #(.beat_t(b_beat_t), .SIG("s_b"), .CAPACITY(2 * NUM_PIPES)) i_b_check (
        .clk(clk), .in_valid(m_bvalid), .in_ready(m_bready), .in_data(m_b),
        .out_valid(s_bvalid), .out_ready(s_bready), .out_data(s_b),
        .pending(pending[2]), .error(chk_err[2]));
    tb_channel_checker #(.beat_t(ar_beat_t), .SIG("m_ar"), .CAPACITY(NUM_PIPES)) i_ar_check (
        .clk(clk), .in_valid(s_arvalid), .in_ready(s_arready), .in_data(s_ar),
        .out_valid(m_arvalid), .out_ready(m_arready), .out_data(m_ar),
        .pending(pending[3]), .error(chk_err[3]));
    tb_channel_checker #(.beat_t(r_beat_t), .SIG("s_r"), .CAPACITY(0)) i_r_check (
        .clk(clk), .in_valid(m_rvalid), .in_ready(m_rready), .in_data(m_r),
        .out_valid(s_rvalid), .out_ready(s_rready), .out_data(s_r),
        .pending(pending[4]), .error(chk_err[4]));

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_bit(input string sig, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("ERROR: %s expected %h, actual %h", sig, expected, actual));
        end
    endtask

    task automatic check_r_beat(input string sig, input r_beat_t expected, input r_beat_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("ERROR: %s expected %h, actual %h", sig, expected, actual));
        end
    endtask

    task automatic check_outbound_idle();
        check_bit("m_awvalid", 1'b0, m_awvalid);
        check_bit("m_wvalid", 1'b0, m_wvalid);
        check_bit("m_arvalid", 1'b0, m_arvalid);
        check_bit("s_bvalid", 1'b0, s_bvalid);
        check_bit("s_rvalid", 1'b0, s_rvalid);
    endtask

    function automatic bit all_idle();
        bit idle;
        idle = !(s_awvalid || s_wvalid || s_arvalid || m_bvalid || m_rvalid);
        foreach (pending[i]) begin
            if (pending[i] != 0) begin
                idle = 1'b0;
            end
        end
        return idle;
    endfunction

    function automatic logic exit_fire(input int ch);
        if (ch == 0) begin
            return m_awvalid && m_awready;
        end
        return s_bvalid && s_bready;
    endfunction

    // Stop new beats, open every exit and wait for the chain to empty
    task automatic drain(input string phase);
        int cycles;
        stim_on  = 1'b0;
        rdy_rate = 100;
        cycles   = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_failure($sformatf("Channels did not drain after the %s phase", phase));
            end
        end while (!all_idle());
    endtask

    task automatic wait_entry_blocked();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_failure("Entry ready never fell while every exit was stalled");
            end
        end while (s_awready || s_wready || m_bready || s_arready || m_rready);
    endtask

    // Once the first beat emerges, one transfer every cycle
    task automatic check_full_rate(input int ch, input string sig);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_failure($sformatf("No transfer on %s while streaming", sig));
            end
        end while (!exit_fire(ch));
        repeat (16) begin
            @(negedge clk);
            check_bit(sig, 1'b1, exit_fire(ch));
        end
    endtask

    // --------------------------------------------------
    // Random drivers on both sides
    // --------------------------------------------------
    always @(posedge clk) begin : drive
        logic [383:0] rnd;
        for (int k = 0; k < 12; k++) begin
            rnd[k*32 +: 32] = $urandom;
        end
        // A raised valid keeps its beat until the handshake
        if (!s_awvalid || s_awready) begin
            s_awvalid <= stim_on && ($urandom % 100 < req_rate);
            s_aw      <= rnd[0 +: $bits(aw_beat_t)];
        end
        if (!s_wvalid || s_wready) begin
            s_wvalid <= stim_on && ($urandom % 100 < req_rate);
            s_w      <= rnd[64 +: $bits(w_beat_t)];
        end
        if (!m_bvalid || m_bready) begin
            m_bvalid <= stim_on && ($urandom % 100 < req_rate);
            m_b      <= rnd[160 +: $bits(b_beat_t)];
        end
        if (!s_arvalid || s_arready) begin
            s_arvalid <= stim_on && ($urandom % 100 < req_rate);
            s_ar      <= rnd[192 +: $bits(ar_beat_t)];
        end
        if (!m_rvalid || m_rready) begin
            m_rvalid <= stim_on && ($urandom % 100 < req_rate);
            m_r      <= rnd[256 +: $bits(r_beat_t)];
        end
        m_awready <= $urandom % 100 < rdy_rate;
        m_wready  <= $urandom % 100 < rdy_rate;
        m_arready <= $urandom % 100 < rdy_rate;
        s_bready  <= $urandom % 100 < rdy_rate;
        s_rready  <= $urandom % 100 < rdy_rate;
    end

    always @(posedge clk) begin
        if (|chk_err) begin
            stop_with_failure("A channel scoreboard reported a failure");
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            // R path is all bypass, both sides in the same cycle
            check_bit("s_rvalid", m_rvalid, s_rvalid);
            check_bit("m_rready", s_rready, m_rready);
            if (m_rvalid) begin
                check_r_beat("s_r", m_r, s_r);
            end
            if (freeze) begin
                check_bit("m_awvalid", 1'b0, m_awvalid);
                check_bit("m_wvalid", 1'b0, m_wvalid);
                check_bit("m_arvalid", 1'b0, m_arvalid);
                if (m_bvalid && m_bready) begin
                    frozen_b++;
                end
                if (s_rvalid && s_rready) begin
                    frozen_r++;
                end
            end
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        void'($urandom(21625));
        rst_n     = 1'b0;
        freeze    = 1'b0;
        s_awvalid = 1'b0;
        s_aw      = '0;
        s_wvalid  = 1'b0;
        s_w       = '0;
        s_bready  = 1'b0;
        s_arvalid = 1'b0;
        s_ar      = '0;
        s_rready  = 1'b0;
        m_awready = 1'b0;
        m_wready  = 1'b0;
        m_bvalid  = 1'b0;
        m_b       = '0;
        m_arready = 1'b0;
        m_rvalid  = 1'b0;
        m_r       = '0;

        repeat (8) begin
            @(negedge clk);
            check_outbound_idle();
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_outbound_idle();

        // Random valid gaps and ready levels
        stim_on  = 1'b1;
        req_rate = 60;
        rdy_rate = 70;
        repeat (500) @(negedge clk);
        drain("random traffic");

        // Every exit stalled
        stim_on  = 1'b1;
        req_rate = 100;
        rdy_rate = 0;
        wait_entry_blocked();
        repeat (40) @(negedge clk);
        drain("back-pressure");

        // Freeze with traffic running
        stim_on  = 1'b1;
        req_rate = 60;
        rdy_rate = 70;
        @(posedge clk);
        freeze <= 1'b1;
        repeat (100) @(posedge clk);
        freeze <= 1'b0;
        @(negedge clk);
        if (frozen_b == 0 || frozen_r == 0) begin
            stop_with_failure("B or R made no transfer while freeze was high");
        end
        repeat (100) @(negedge clk);
        drain("freeze");

        req_rate = 100;
        rdy_rate = 100;
        stim_on  = 1'b1;
        check_full_rate(0, "m_aw handshake");
        check_full_rate(1, "s_b handshake");
        drain("streaming");

        // Scoreboards settle on the falling edge, so look one rising edge later
        @(posedge clk);
        if (chk_err == '0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            stop_with_failure("A channel scoreboard failed on the last beats");
        end
    end

endmodule

`default_nettype wire

//--- all.f
src/axi_mmio_pkg.sv
src/axi_pipe_stage.sv
src/axi_register.sv
src/axi_mmio_register.sv
test/tb_channel_checker.sv
test/tb_axi_mmio_register.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_axi_mmio_register -f all.f -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
